/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int ADDR_W            = 32;
    localparam int WORD_W            = 32;
    localparam int STRB_W            = WORD_W / 8;
    localparam int LEN_W             = 3;                        // Holds a count of 1 to 4 beats
    localparam int BLOCK_BYTES       = 16;
    localparam int BLOCK_WORDS       = BLOCK_BYTES / STRB_W;     // Also the refill burst length
    localparam int ICACHE_LINES      = 32;
    localparam int BYTE_OFFSET_BITS  = $clog2(BLOCK_BYTES);
    localparam int OFFSET_BITS       = $clog2(BLOCK_WORDS);
    localparam int INDEX_BITS        = $clog2(ICACHE_LINES);
    localparam int TAG_BITS          = ADDR_W - INDEX_BITS - BYTE_OFFSET_BITS;
    localparam int CLINT_OFFSET_BITS = 16;

    localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [ADDR_W-1:0] CLINT_MASK = 32'h0000_FFFF;  // 64 KiB timer window

    localparam logic [CLINT_OFFSET_BITS-1:0] MTIME_LO_OFFSET = 16'hBFF8;
    localparam logic [CLINT_OFFSET_BITS-1:0] MTIME_HI_OFFSET = 16'hBFFC;

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [STRB_W-1:0]            strb_t;
    typedef logic [LEN_W-1:0]             beat_len_t;
    typedef logic [TAG_BITS-1:0]          tag_t;
    typedef logic [INDEX_BITS-1:0]        index_t;
    typedef logic [OFFSET_BITS-1:0]       offset_t;
    typedef logic [CLINT_OFFSET_BITS-1:0] clint_offset_t;
    typedef logic [2*WORD_W-1:0]          mtime_t;

    typedef struct packed {
        addr_t     addr;
        logic      write;
        beat_len_t len;
        word_t     wdata;
        strb_t     strb;
    } mem_req_t;

    typedef struct packed {
        word_t data;
        logic  last;
        logic  write_done;
    } mem_resp_t;

    typedef struct packed {
        addr_t addr;
        logic  write;
        word_t wdata;
        strb_t strb;
    } data_req_t;

    typedef enum logic [1:0] {
        ic_idle,
        ic_lookup,
        ic_refill_req,
        ic_refill_wait
    } icache_state_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_busy_fetch,
        arb_busy_data
    } arb_state_t;

endpackage

`default_nettype wire

/* clint.sv */
`default_nettype none

module clint (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   rd_valid,
    input  wire mem_pkg::clint_offset_t rd_offset,
    output logic                        rd_resp_valid,
    output mem_pkg::word_t              rd_resp_data
);
    import mem_pkg::*;

    mtime_t mtime_q;
    word_t  rd_word;

    always_comb begin
        case (rd_offset)
            MTIME_LO_OFFSET: rd_word = mtime_q[WORD_W-1:0];
            MTIME_HI_OFFSET: rd_word = mtime_q[2*WORD_W-1:WORD_W];
            default:         rd_word = '0;  // Unmapped timer registers
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mtime_q       <= '0;
            rd_resp_valid <= 1'b0;
        end else begin
            mtime_q       <= mtime_q + 1'b1;  // Free running with one tick per clock
            rd_resp_valid <= rd_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_valid) rd_resp_data <= rd_word;
    end

endmodule

`default_nettype wire

/* icache.sv */
`default_nettype none

module icache (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               fetch_valid,
    input  wire mem_pkg::addr_t     fetch_addr,
    output logic                    fetch_ready,
    output logic                    fetch_resp_valid,
    output mem_pkg::word_t          fetch_resp_data,
    input  wire logic               flush,
    output logic                    refill_valid,
    output mem_pkg::mem_req_t       refill_req,
    input  wire logic               refill_ready,
    input  wire logic               refill_beat_valid,
    input  wire mem_pkg::mem_resp_t refill_beat
);
    import mem_pkg::*;

    icache_state_t           state_q;
    logic                    armed_q;
    addr_t                   req_addr_q;
    offset_t                 beat_cnt_q;
    logic                    flush_pending_q;
    logic [ICACHE_LINES-1:0] valid_q;
    tag_t                    tag_q [ICACHE_LINES];
    word_t                   data_q [ICACHE_LINES*BLOCK_WORDS];

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    hit;
    logic    refill_done;
    logic    in_refill;
    logic    flush_apply;

    assign req_tag    = req_addr_q[ADDR_W-1 -: TAG_BITS];
    assign req_index  = req_addr_q[BYTE_OFFSET_BITS +: INDEX_BITS];
    assign req_offset = req_addr_q[BYTE_OFFSET_BITS-1 -: OFFSET_BITS];

    assign hit         = valid_q[req_index] && (tag_q[req_index] == req_tag);
    assign refill_done = (state_q == ic_refill_wait) && refill_beat_valid && refill_beat.last;
    assign in_refill   = ((state_q == ic_refill_req) || (state_q == ic_refill_wait)) &&
                         !refill_done;
    assign flush_apply = (flush || flush_pending_q) && !in_refill;  // Deferred past a live refill

    assign fetch_ready  = armed_q && (state_q == ic_idle);
    assign refill_valid = (state_q == ic_refill_req);

    always_comb begin
        refill_req      = '0;
        refill_req.addr = {req_addr_q[ADDR_W-1:BYTE_OFFSET_BITS], {BYTE_OFFSET_BITS{1'b0}}};
        refill_req.len  = beat_len_t'(BLOCK_WORDS);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q          <= ic_idle;
            armed_q          <= 1'b0;
            beat_cnt_q       <= '0;
            flush_pending_q  <= 1'b0;
            valid_q          <= '0;
            fetch_resp_valid <= 1'b0;
        end else begin
            armed_q          <= 1'b1;
            fetch_resp_valid <= 1'b0;
            case (state_q)
                ic_idle: begin
                    if (fetch_valid && fetch_ready) state_q <= ic_lookup;
                end
                ic_lookup: begin
                    if (hit) begin
                        fetch_resp_valid <= 1'b1;
                        state_q          <= ic_idle;
                    end else begin
                        state_q <= ic_refill_req;
                    end
                end
                ic_refill_req: begin
                    if (refill_ready) begin
                        beat_cnt_q <= '0;
                        state_q    <= ic_refill_wait;
                    end
                end
                ic_refill_wait: begin
                    if (refill_beat_valid) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (refill_beat.last) begin
                            fetch_resp_valid <= 1'b1;
                            state_q          <= ic_idle;
                        end
                    end
                end
                default: state_q <= ic_idle;
            endcase
            if (flush_apply) begin
                valid_q         <= '0;  // A flush at refill end also drops the new line
                flush_pending_q <= 1'b0;
            end else begin
                if (flush) flush_pending_q <= 1'b1;
                if (refill_done) valid_q[req_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_valid && fetch_ready) req_addr_q <= fetch_addr;
        if (state_q == ic_lookup) fetch_resp_data <= data_q[{req_index, req_offset}];
        if ((state_q == ic_refill_wait) && refill_beat_valid) begin
            data_q[{req_index, beat_cnt_q}] <= refill_beat.data;
            if (refill_beat.last) begin
                tag_q[req_index] <= req_tag;
                fetch_resp_data  <= (beat_cnt_q == req_offset) ? refill_beat.data
                                                              : data_q[{req_index, req_offset}];
            end
        end
    end

endmodule

`default_nettype wire

/* data_port.sv */
`default_nettype none

module data_port (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               data_valid,
    input  wire mem_pkg::data_req_t data_req,
    output logic                    data_ready,
    output logic                    data_resp_valid,
    output mem_pkg::word_t          data_resp_data,
    output logic                    mem_port_valid,
    output mem_pkg::mem_req_t       mem_port_req,
    input  wire logic               mem_port_ready,
    input  wire logic               mem_port_beat_valid,
    input  wire mem_pkg::mem_resp_t mem_port_beat
);
    import mem_pkg::*;

    logic     armed_q;
    logic     busy_q;
    logic     mem_pending_q;
    logic     store_ack_q;
    mem_req_t req_q;

    logic  accept;
    logic  in_clint;
    logic  clint_rd_valid;
    logic  clint_resp_valid;
    word_t clint_resp_data;

    assign data_ready     = armed_q && !busy_q;
    assign accept         = data_valid && data_ready;
    assign in_clint       = (data_req.addr & ~CLINT_MASK) == CLINT_BASE;
    assign clint_rd_valid = accept && in_clint && !data_req.write;

    clint clint_i (
        .clock         (clock                                      ),
        .reset         (reset                                      ),
        .rd_valid      (clint_rd_valid                             ),
        .rd_offset     (data_req.addr[CLINT_OFFSET_BITS-1:0]       ),
        .rd_resp_valid (clint_resp_valid                           ),
        .rd_resp_data  (clint_resp_data                            )
    );

    assign mem_port_valid  = mem_pending_q;
    assign mem_port_req    = req_q;
    assign data_resp_valid = clint_resp_valid || store_ack_q || mem_port_beat_valid;

    always_comb begin
        if (clint_resp_valid) data_resp_data = clint_resp_data;
        else if (mem_port_beat_valid && !mem_port_beat.write_done) data_resp_data = mem_port_beat.data;
        else data_resp_data = '0;  // Stores answer with zero
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            armed_q       <= 1'b0;
            busy_q        <= 1'b0;
            mem_pending_q <= 1'b0;
            store_ack_q   <= 1'b0;
        end else begin
            armed_q     <= 1'b1;
            store_ack_q <= accept && in_clint && data_req.write;  // Timer stores are dropped
            if (accept) begin
                busy_q <= 1'b1;
                if (!in_clint) mem_pending_q <= 1'b1;
            end else if (data_resp_valid) begin
                busy_q <= 1'b0;
            end
            if (mem_port_valid && mem_port_ready) mem_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q.addr  <= data_req.addr;
            req_q.write <= data_req.write;
            req_q.len   <= beat_len_t'(1);
            req_q.wdata <= data_req.wdata;
            req_q.strb  <= data_req.strb;
        end
    end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               fetch_req_valid,
    input  wire mem_pkg::mem_req_t  fetch_req,
    output logic                    fetch_req_ready,
    output logic                    fetch_beat_valid,
    output mem_pkg::mem_resp_t      fetch_beat,
    input  wire logic               data_req_valid,
    input  wire mem_pkg::mem_req_t  data_req,
    output logic                    data_req_ready,
    output logic                    data_beat_valid,
    output mem_pkg::mem_resp_t      data_beat,
    output logic                    mem_valid,
    output mem_pkg::mem_req_t       mem_req,
    input  wire logic               mem_ready,
    input  wire logic               mem_resp_valid,
    input  wire mem_pkg::mem_resp_t mem_resp
);
    import mem_pkg::*;

    arb_state_t state_q;
    logic       release_grant;

    // Grant ends with the final read beat or the write acknowledge
    assign release_grant = mem_resp_valid && (mem_resp.last || mem_resp.write_done);

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= arb_idle;
        end else begin
            case (state_q)
                arb_idle: begin
                    if (data_req_valid) state_q <= arb_busy_data;  // Data side wins a tie
                    else if (fetch_req_valid) state_q <= arb_busy_fetch;
                end
                arb_busy_fetch,
                arb_busy_data: begin
                    if (release_grant) state_q <= arb_idle;
                end
                default: state_q <= arb_idle;
            endcase
        end
    end

    always_comb begin
        mem_valid        = 1'b0;
        mem_req          = '0;
        fetch_req_ready  = 1'b0;
        data_req_ready   = 1'b0;
        fetch_beat_valid = 1'b0;
        data_beat_valid  = 1'b0;
        case (state_q)
            arb_busy_fetch: begin
                mem_valid        = fetch_req_valid;
                mem_req          = fetch_req;
                fetch_req_ready  = mem_ready;
                fetch_beat_valid = mem_resp_valid;
            end
            arb_busy_data: begin
                mem_valid       = data_req_valid;
                mem_req         = data_req;
                data_req_ready  = mem_ready;
                data_beat_valid = mem_resp_valid;
            end
            default: ;
        endcase
    end

    assign fetch_beat = mem_resp;
    assign data_beat  = mem_resp;

endmodule

`default_nettype wire

/* mem_subsystem.sv */
`default_nettype none

module mem_subsystem (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               fetch_valid,
    input  wire mem_pkg::addr_t     fetch_addr,
    output logic                    fetch_ready,
    output logic                    fetch_resp_valid,
    output mem_pkg::word_t          fetch_resp_data,
    input  wire logic               icache_flush,
    input  wire logic               data_valid,
    input  wire mem_pkg::data_req_t data_req,
    output logic                    data_ready,
    output logic                    data_resp_valid,
    output mem_pkg::word_t          data_resp_data,
    output logic                    mem_valid,
    output mem_pkg::mem_req_t       mem_req,
    input  wire logic               mem_ready,
    input  wire logic               mem_resp_valid,
    input  wire mem_pkg::mem_resp_t mem_resp
);
    import mem_pkg::*;

    logic      refill_valid;
    mem_req_t  refill_req;
    logic      refill_ready;
    logic      refill_beat_valid;
    mem_resp_t refill_beat;
    logic      dport_valid;
    mem_req_t  dport_req;
    logic      dport_ready;
    logic      dport_beat_valid;
    mem_resp_t dport_beat;

    icache icache_i (
        .clock             (clock            ),
        .reset             (reset            ),
        .fetch_valid       (fetch_valid      ),
        .fetch_addr        (fetch_addr       ),
        .fetch_ready       (fetch_ready      ),
        .fetch_resp_valid  (fetch_resp_valid ),
        .fetch_resp_data   (fetch_resp_data  ),
        .flush             (icache_flush     ),
        .refill_valid      (refill_valid     ),
        .refill_req        (refill_req       ),
        .refill_ready      (refill_ready     ),
        .refill_beat_valid (refill_beat_valid),
        .refill_beat       (refill_beat      )
    );

    data_port data_port_i (
        .clock               (clock           ),
        .reset               (reset           ),
        .data_valid          (data_valid      ),
        .data_req            (data_req        ),
        .data_ready          (data_ready      ),
        .data_resp_valid     (data_resp_valid ),
        .data_resp_data      (data_resp_data  ),
        .mem_port_valid      (dport_valid     ),
        .mem_port_req        (dport_req       ),
        .mem_port_ready      (dport_ready     ),
        .mem_port_beat_valid (dport_beat_valid),
        .mem_port_beat       (dport_beat      )
    );

    mem_arbiter mem_arbiter_i (
        .clock            (clock            ),
        .reset            (reset            ),
        .fetch_req_valid  (refill_valid     ),
        .fetch_req        (refill_req       ),
        .fetch_req_ready  (refill_ready     ),
        .fetch_beat_valid (refill_beat_valid),
        .fetch_beat       (refill_beat      ),
        .data_req_valid   (dport_valid      ),
        .data_req         (dport_req        ),
        .data_req_ready   (dport_ready      ),
        .data_beat_valid  (dport_beat_valid ),
        .data_beat        (dport_beat       ),
        .mem_valid        (mem_valid        ),
        .mem_req          (mem_req          ),
        .mem_ready        (mem_ready        ),
        .mem_resp_valid   (mem_resp_valid   ),
        .mem_resp         (mem_resp         )
    );

endmodule

`default_nettype wire

/* tb_mem_assert.sv */
`default_nettype none

module tb_mem_assert (
    input wire logic               clock,
    input wire logic               reset,
    input wire logic               mem_valid,
    input wire logic               mem_ready,
    input wire mem_pkg::mem_req_t  mem_req,
    input wire logic               mem_resp_valid,
    input wire mem_pkg::mem_resp_t mem_resp,
    input wire logic               fetch_beat_valid,
    input wire logic               data_beat_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic outstanding_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding_q <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            outstanding_q <= 1'b1;
        end else if (mem_resp_valid && (mem_resp.last || mem_resp.write_done)) begin
            outstanding_q <= 1'b0;
        end
    end

    // A stalled request holds its content until accepted
    assert property (@(posedge clock) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
        else $error("master request changed while stalled");

    assert property (@(posedge clock) disable iff (reset)
        mem_resp_valid |-> (fetch_beat_valid != data_beat_valid))
        else $error("response beat not routed to exactly one owner");

    assert property (@(posedge clock) disable iff (reset)
        outstanding_q |-> !(mem_valid && mem_ready))
        else $error("second request granted while one is outstanding");

endmodule

bind mem_arbiter tb_mem_assert mem_assert_i (.*);

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

module tb_checker (
    input wire logic              clock,
    input wire logic              reset,
    input wire logic              mem_valid,
    input wire logic              mem_ready,
    input wire mem_pkg::mem_req_t mem_req
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    int    errors;
    int    checks;
    int    req_count;
    addr_t req_addr_log [64];
    word_t ref_mem [1024];

    initial begin
        errors    = 0;
        checks    = 0;
        req_count = 0;
        for (int i = 0; i < 1024; i++) ref_mem[i] = ~addr_t'(i * 4);
    end

    task automatic report_failure(input string what);
        errors = errors + 1;
        $display("** Error %s", what);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("** Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_increase(input string name, input word_t prev, input word_t actual);
        checks = checks + 1;
        if (actual <= prev) begin
            errors = errors + 1;
            $display("** Error %s expected above %h actual %h", name, prev, actual);
        end
    endtask

    task automatic check_ref(input string name, input addr_t addr, input word_t actual);
        check_value({name, "_ref"}, ref_mem[addr[11:2]], actual);
    endtask

    task automatic print_summary();
        $display("checks %0d errors %0d master requests %0d", checks, errors, req_count);
    endtask

    // Count accepted master requests and mirror stores into the reference copy
    always @(posedge clock) begin
        if (!reset && mem_valid && mem_ready) begin
            if (req_count < 64) req_addr_log[req_count] = mem_req.addr;
            req_count = req_count + 1;
            if (mem_req.len == beat_len_t'(BLOCK_WORDS) && mem_req.addr[3:0] != 4'h0)
                report_failure("refill request is not block aligned");
            if (mem_req.write) begin
                for (int b = 0; b < STRB_W; b++)
                    if (mem_req.strb[b]) ref_mem[mem_req.addr[11:2]][8*b +: 8] = mem_req.wdata[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* tb_mem_subsystem.sv */
`default_nettype none

module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam int K_FETCH   = 0;
    localparam int K_LOAD    = 1;
    localparam int K_STORE   = 2;
    localparam int K_FLUSH   = 3;
    localparam int K_MTIME   = 4;
    localparam int K_BOTH    = 5;  // Load at addr and fetch at data in the same cycle
    localparam int NUM_TESTS = 10;
    localparam int TIMEOUT   = 200;

    typedef struct {
        string name;
        int    kind;
        addr_t addr;
        word_t data;
        strb_t strb;
        word_t expected;
        int    new_reqs;
    } test_entry_t;

    logic      clock;
    logic      reset;
    logic      fetch_valid;
    addr_t     fetch_addr;
    logic      fetch_ready;
    logic      fetch_resp_valid;
    word_t     fetch_resp_data;
    logic      icache_flush;
    logic      data_valid;
    data_req_t data_req;
    logic      data_ready;
    logic      data_resp_valid;
    word_t     data_resp_data;
    logic      mem_valid;
    mem_req_t  mem_req;
    logic      mem_ready;
    logic      mem_resp_valid;
    mem_resp_t mem_resp;

    test_entry_t tests [NUM_TESTS];
    word_t       model_mem [1024];
    logic        model_busy;
    mem_req_t    model_req;
    int          model_beat;
    int          seed;
    logic        timed_out;
    word_t       prev_mtime;

    mem_subsystem mem_subsystem_i (.*);

    tb_checker checker_i (
        .clock     (clock    ),
        .reset     (reset    ),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_req   (mem_req  )
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic word_t merge_bytes(input word_t old, input word_t wdata, input strb_t strb);
        word_t result;
        result = old;
        for (int b = 0; b < STRB_W; b++)
            if (strb[b]) result[8*b +: 8] = wdata[8*b +: 8];
        return result;
    endfunction

    // Memory model accepts on the rising edge and answers beats on falling edges
    always @(posedge clock) begin
        if (!reset && mem_valid && mem_ready && !model_busy) begin
            model_busy = 1'b1;
            model_req  = mem_req;
            model_beat = 0;
        end
    end

    always @(negedge clock) begin
        mem_resp_valid = 1'b0;
        mem_resp       = '0;
        if (reset) begin
            model_busy = 1'b0;
        end else if (model_busy) begin
            mem_resp_valid = 1'b1;
            if (model_req.write) begin
                model_mem[model_req.addr[11:2]] = merge_bytes(model_mem[model_req.addr[11:2]],
                                                              model_req.wdata, model_req.strb);
                mem_resp.write_done = 1'b1;
                model_busy          = 1'b0;
            end else begin
                mem_resp.data = model_mem[model_req.addr[11:2] + 10'(model_beat)];
                model_beat    = model_beat + 1;
                if (model_beat == int'(model_req.len)) begin
                    mem_resp.last = 1'b1;
                    model_busy    = 1'b0;
                end
            end
        end
        mem_ready = !model_busy && ($random(seed) % 4 != 0);  // Random back-pressure
    end

    task automatic add_test(input int idx, input string name, input int kind, input addr_t addr,
                            input word_t data, input strb_t strb, input word_t expected,
                            input int new_reqs);
        tests[idx] = '{name, kind, addr, data, strb, expected, new_reqs};
    endtask

    task automatic load_tests();
        add_test(0, "fetch_miss", K_FETCH, 32'h104, '0, '0, ~32'h104, 1);
        add_test(1, "fetch_hit", K_FETCH, 32'h108, '0, '0, ~32'h108, 0);
        add_test(2, "flush", K_FLUSH, '0, '0, '0, '0, 0);
        add_test(3, "fetch_after_flush", K_FETCH, 32'h104, '0, '0, ~32'h104, 1);
        add_test(4, "store_partial", K_STORE, 32'h200, 32'hA5A5_1234, 4'b0101, '0, 1);
        add_test(5, "load_merged", K_LOAD, 32'h200, '0, '0,
                 merge_bytes(~32'h200, 32'hA5A5_1234, 4'b0101), 1);
        add_test(6, "mtime_lo_first", K_MTIME, 32'h0200_BFF8, '0, '0, '0, 0);
        add_test(7, "mtime_lo_second", K_MTIME, 32'h0200_BFF8, '0, '0, '0, 0);
        add_test(8, "mtime_hi", K_MTIME, 32'h0200_BFFC, '0, '0, '0, 0);
        add_test(9, "arb_load_fetch", K_BOTH, 32'h300, 32'h340, '0, ~32'h300, 2);
    endtask

    task automatic run_test(input test_entry_t t, input bit first_mtime);
        int    reqs_before;
        int    cycles;
        int    fetch_cycles;
        bit    need_fetch;
        bit    need_data;
        bit    fetch_seen;
        bit    data_seen;
        word_t fetch_word;
        word_t data_word;
        reqs_before = checker_i.req_count;
        need_fetch  = (t.kind == K_FETCH) || (t.kind == K_BOTH);
        need_data   = (t.kind != K_FETCH) && (t.kind != K_FLUSH);
        fetch_seen  = 1'b0;
        data_seen   = 1'b0;
        fetch_word  = '0;
        data_word   = '0;
        fetch_cycles = 0;
        if (t.kind == K_FLUSH) begin
            icache_flush = 1'b1;
            @(negedge clock);
            icache_flush = 1'b0;
        end else begin
            fetch_valid   = need_fetch;
            fetch_addr    = (t.kind == K_BOTH) ? t.data : t.addr;
            data_valid    = need_data;
            data_req      = '0;
            data_req.addr = t.addr;
            data_req.write = (t.kind == K_STORE);
            data_req.wdata = t.data;
            data_req.strb  = t.strb;
            cycles = 0;
            while (!((!need_fetch || fetch_ready) && (!need_data || data_ready)) &&
                   cycles < TIMEOUT) begin
                @(negedge clock);
                cycles++;
            end
            if (cycles >= TIMEOUT) begin
                timed_out = 1'b1;
                checker_i.report_failure({t.name, " timed out waiting for ready"});
            end else begin
                cycles = 0;
                @(negedge clock);
                fetch_valid = 1'b0;
                data_valid  = 1'b0;
                do begin
                    @(posedge clock);  // Responses can be combinational from the memory model
                    cycles++;
                    if (fetch_resp_valid && !fetch_seen) begin
                        fetch_seen   = 1'b1;
                        fetch_word   = fetch_resp_data;
                        fetch_cycles = cycles;
                    end
                    if (data_resp_valid && !data_seen) begin
                        data_seen = 1'b1;
                        data_word = data_resp_data;
                    end
                end while (!((fetch_seen || !need_fetch) && (data_seen || !need_data)) &&
                           cycles < TIMEOUT);
                @(negedge clock);
                if (cycles >= TIMEOUT) begin
                    timed_out = 1'b1;
                    checker_i.report_failure({t.name, " timed out waiting for a response"});
                end
            end
        end
        if (!timed_out) begin
            case (t.kind)
                K_FETCH: begin
                    checker_i.check_value(t.name, t.expected, fetch_word);
                    if (t.new_reqs == 0)
                        checker_i.check_value({t.name, "_latency"}, 2, word_t'(fetch_cycles));
                end
                K_LOAD, K_STORE: begin
                    checker_i.check_value(t.name, t.expected, data_word);
                    if (t.kind == K_LOAD) checker_i.check_ref(t.name, t.addr, data_word);
                end
                K_MTIME: begin
                    if (t.addr[2]) checker_i.check_value(t.name, '0, data_word);
                    else if (!first_mtime) checker_i.check_increase(t.name, prev_mtime, data_word);
                    if (!t.addr[2]) prev_mtime = data_word;
                end
                K_BOTH: begin
                    checker_i.check_value({t.name, "_data"}, t.expected, data_word);
                    checker_i.check_value({t.name, "_fetch"}, ~t.data, fetch_word);
                    checker_i.check_value({t.name, "_order"}, t.addr,
                                          checker_i.req_addr_log[reqs_before]);
                end
                default: ;
            endcase
            checker_i.check_value({t.name, "_reqs"}, word_t'(t.new_reqs),
                                  word_t'(checker_i.req_count - reqs_before));
        end
    endtask

    initial begin
        seed           = 90;
        timed_out      = 1'b0;
        prev_mtime     = '0;
        model_busy     = 1'b0;
        model_req      = '0;
        model_beat     = 0;
        reset          = 1'b1;
        fetch_valid    = 1'b0;
        fetch_addr     = '0;
        icache_flush   = 1'b0;
        data_valid     = 1'b0;
        data_req       = '0;
        mem_ready      = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp       = '0;
        for (int i = 0; i < 1024; i++) model_mem[i] = ~addr_t'(i * 4);
        load_tests();
        repeat (16) @(negedge clock);
        reset = 1'b0;
        checker_i.check_value("ready_after_reset", '0, word_t'(fetch_ready | data_ready));
        for (int i = 0; i < NUM_TESTS && !timed_out; i++)
            run_test(tests[i], tests[i].name == "mtime_lo_first");
        checker_i.print_summary();
        if (timed_out || checker_i.errors != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
mem_pkg.sv
clint.sv
icache.sv
data_port.sv
mem_arbiter.sv
mem_subsystem.sv
tb_mem_assert.sv
tb_checker.sv
tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsystem -f filelist.f -o sim_mem_subsystem

sim_out=$(./obj_dir/sim_mem_subsystem)
echo "$sim_out"
echo "$sim_out" | grep -qx "test passed"
